// ==== riscv_core.f ====
hw/riscv_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/imm_gen.sv
hw/alu.sv
hw/lsu.sv
hw/csr_unit.sv
hw/riscv_core.sv
test/tb_riscv_core.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f riscv_core.f --top-module tb_riscv_core \
    -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qF '*** TEST PASSED ***' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_core;
    import riscv_pkg::*;

    localparam int IMEM_W = 10;

    logic              clk;
    logic              rst;
    logic              run;
    logic              imem_wr_en;
    logic [IMEM_W-1:0] imem_wr_addr;
    logic [31:0]       imem_wr_data;
    logic [31:0]       tohost;
    logic              tohost_valid;

    logic [31:0] prog [$];
    logic [31:0] exp_q [$];
    logic [7:0]  mem_model [16];
    int          cycles = 0;
    int          cycle_limit;
    int          errors;

    riscv_core #(
        .RESET_PC    (32'h0000_0000),
        .IMEM_ADDR_W (IMEM_W),
        .DMEM_ADDR_W (10)
    ) i_riscv_core (
        .clk(clk), .rst(rst), .run(run),
        .imem_wr_en(imem_wr_en), .imem_wr_addr(imem_wr_addr), .imem_wr_data(imem_wr_data),
        .tohost(tohost), .tohost_valid(tohost_valid)
    );

    always #10 clk = ~clk;

    // watchdog limit grows with each loaded program
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles without a result", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // instruction word builders on top of the package union
    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        inst_t w;
        w.r_fmt.funct7 = f7[6:0];
        w.r_fmt.rs2    = rs2[4:0];
        w.r_fmt.rs1    = rs1[4:0];
        w.r_fmt.funct3 = f3[2:0];
        w.r_fmt.rd     = rd[4:0];
        w.r_fmt.opcode = OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, opcode_e op);
        inst_t w;
        w.i_fmt.imm    = imm[11:0];
        w.i_fmt.rs1    = rs1[4:0];
        w.i_fmt.funct3 = f3[2:0];
        w.i_fmt.rd     = rd[4:0];
        w.i_fmt.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
        inst_t w;
        w.s_fmt.imm_hi = imm[11:5];
        w.s_fmt.rs2    = rs2[4:0];
        w.s_fmt.rs1    = rs1[4:0];
        w.s_fmt.funct3 = f3[2:0];
        w.s_fmt.imm_lo = imm[4:0];
        w.s_fmt.opcode = OPC_STORE;
        return w;
    endfunction

    function automatic logic [31:0] b_type(int off, int rs2, int rs1, int f3);
        inst_t w;
        w.b_fmt.imm_12   = off[12];
        w.b_fmt.imm_10_5 = off[10:5];
        w.b_fmt.rs2      = rs2[4:0];
        w.b_fmt.rs1      = rs1[4:0];
        w.b_fmt.funct3   = f3[2:0];
        w.b_fmt.imm_4_1  = off[4:1];
        w.b_fmt.imm_11   = off[11];
        w.b_fmt.opcode   = OPC_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] u_type(int imm, int rd, opcode_e op);
        inst_t w;
        w.u_fmt.imm    = imm[19:0];
        w.u_fmt.rd     = rd[4:0];
        w.u_fmt.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] j_type(int off, int rd);
        inst_t w;
        w.j_fmt.imm_20    = off[20];
        w.j_fmt.imm_10_1  = off[10:1];
        w.j_fmt.imm_11    = off[11];
        w.j_fmt.imm_19_12 = off[19:12];
        w.j_fmt.rd        = rd[4:0];
        w.j_fmt.opcode    = OPC_JAL;
        return w;
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return i_type(imm, rs1, 0, rd, OPC_OP_IMM);
    endfunction

    function automatic logic [31:0] csr_rw(int rd, int csr, int rs1);
        return i_type(csr, rs1, 1, rd, OPC_SYSTEM);
    endfunction

    function automatic logic [31:0] csr_rwi(int rd, int csr, int uimm);
        return i_type(csr, uimm, 5, rd, OPC_SYSTEM);
    endfunction

    function automatic logic [31:0] sext12(int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    task automatic emit(logic [31:0] word);
        prog.push_back(word);
    endtask

    // report a register and spin on jal x0,0
    task automatic emit_report_halt(int rs);
        emit(csr_rw(0, int'(CSR_TOHOST), rs));
        emit(j_type(0, 0));
    endtask

    task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "flag mismatch");
        end
    endtask

    // hold the core and write the program word by word
    task automatic load_program();
        @(posedge clk);
        run <= 1'b0;
        repeat (3) @(posedge clk);
        for (int i = 0; i < prog.size(); i++) begin
            imem_wr_en   <= 1'b1;
            imem_wr_addr <= i[IMEM_W-1:0];
            imem_wr_data <= prog[i];
            @(posedge clk);
        end
        imem_wr_en  <= 1'b0;
        cycle_limit += prog.size() * 20;
    endtask

    task automatic start_program();
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic wait_result(output logic [31:0] value);
        do begin
            @(negedge clk);
        end while (!tohost_valid);
        value = tohost;
    endtask

    task automatic dependent_alu_chain();
        logic [31:0] a [14];
        logic [31:0] got;
        prog.delete();
        emit(addi(1, 0, 123));
        emit(addi(2, 0, -45));
        emit(r_type(7'h00, 2, 1, 0, 3));
        emit(r_type(7'h20, 1, 3, 0, 4));
        emit(r_type(7'h00, 1, 4, 4, 5));
        emit(i_type(12'h5a5, 5, 4, 6, OPC_OP_IMM));
        emit(r_type(7'h00, 1, 6, 2, 7));
        emit(r_type(7'h20, 7, 2, 5, 8));
        emit(i_type(32'h403, 6, 5, 9, OPC_OP_IMM));
        emit(r_type(7'h00, 7, 8, 1, 10));
        emit(i_type(4, 10, 1, 11, OPC_OP_IMM));
        emit(r_type(7'h00, 9, 11, 0, 13));
        emit(r_type(7'h00, 7, 13, 0, 13));
        emit_report_halt(13);
        a[1]  = 32'd123;
        a[2]  = sext12(-45);
        a[3]  = a[1] + a[2];
        a[4]  = a[3] - a[1];
        a[5]  = a[4] ^ a[1];
        a[6]  = a[5] ^ sext12(12'h5a5);
        a[7]  = {31'd0, $signed(a[6]) < $signed(a[1])};
        a[8]  = $signed(a[2]) >>> a[7][4:0];
        a[9]  = $signed(a[6]) >>> 3;
        a[10] = a[8] << a[7][4:0];
        a[11] = a[10] << 4;
        a[13] = a[11] + a[9] + a[7];
        load_program();
        start_program();
        wait_result(got);
        check_word("alu chain", got, a[13]);
    endtask

    task automatic build_countdown(int n);
        prog.delete();
        emit(addi(1, 0, n));
        emit(addi(2, 0, 0));
        emit(r_type(7'h00, 1, 2, 0, 2));
        emit(addi(1, 1, -1));
        emit(b_type(-8, 0, 1, 1));
        emit_report_halt(2);
    endtask

    task automatic branch_and_jump();
        logic [31:0] got;
        build_countdown(10);
        load_program();
        start_program();
        wait_result(got);
        check_word("countdown sum", got, 32'd55);
        // markers 31 and 30 sit in the slot behind each jump
        prog.delete();
        emit(addi(6, 0, 28));
        emit(j_type(12, 1));
        emit(csr_rwi(0, int'(CSR_TOHOST), 31));
        emit(j_type(0, 0));
        emit(i_type(0, 6, 0, 2, OPC_JALR));
        emit(csr_rwi(0, int'(CSR_TOHOST), 30));
        emit(j_type(0, 0));
        emit(csr_rw(0, int'(CSR_TOHOST), 1));
        emit_report_halt(2);
        load_program();
        start_program();
        wait_result(got);
        check_word("jal link", got, 32'd8);
        wait_result(got);
        check_word("jalr link", got, 32'd20);
    endtask

    task automatic store_model(int off, logic [31:0] val, int f3);
        for (int b = 0; b < (1 << f3); b++) begin
            mem_model[off + b] = val[8*b +: 8];
        end
    endtask

    // little-endian read with RV32I extension rules
    function automatic logic [31:0] load_model(int off, int f3);
        logic [31:0] raw;
        raw = {mem_model[(off + 3) & 15], mem_model[(off + 2) & 15],
               mem_model[(off + 1) & 15], mem_model[off & 15]};
        case (f3)
            0:       return {{24{raw[7]}}, raw[7:0]};
            1:       return {{16{raw[15]}}, raw[15:0]};
            4:       return {24'd0, raw[7:0]};
            5:       return {16'd0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic add_store(int rs, logic [31:0] val, int f3, int off);
        emit(s_type(off, rs, 10, f3));
        store_model(off, val, f3);
    endtask

    task automatic add_load(int rd, int f3, int off);
        emit(i_type(off, 10, f3, rd, OPC_LOAD));
        emit(csr_rw(0, int'(CSR_TOHOST), rd));
        exp_q.push_back(load_model(off, f3));
    endtask

    task automatic load_store_lanes();
        logic [31:0] got;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        prog.delete();
        exp_q.delete();
        x1 = 32'h1234_5678;
        x2 = 32'h0000_00ab;
        x3 = 32'hffff_fffe;
        emit(addi(10, 0, 12'h100));
        emit(u_type(20'h12345, 1, OPC_LUI));
        emit(addi(1, 1, 12'h678));
        emit(addi(2, 0, 12'h0ab));
        emit(addi(3, 0, -2));
        add_store(1, x1, 2, 0);
        add_store(2, x2, 0, 1);
        add_store(3, x3, 1, 2);
        add_store(0, 32'd0, 2, 8);
        add_store(2, x2, 0, 8);
        add_store(3, x3, 0, 9);
        add_store(1, x1, 0, 10);
        add_store(2, x2, 0, 11);
        add_store(1, x1, 1, 12);
        add_store(2, x2, 1, 14);
        add_load(11, 2, 0);
        add_load(12, 0, 1);
        add_load(13, 4, 1);
        add_load(14, 1, 2);
        add_load(15, 5, 2);
        add_load(16, 0, 11);
        add_load(17, 4, 9);
        add_load(18, 1, 8);
        add_load(19, 5, 14);
        add_load(20, 2, 8);
        add_load(21, 2, 12);
        // load used by the very next instruction
        emit(i_type(3, 10, 0, 22, OPC_LOAD));
        emit(r_type(7'h00, 22, 22, 0, 23));
        emit_report_halt(23);
        exp_q.push_back(load_model(3, 0) + load_model(3, 0));
        load_program();
        start_program();
        foreach (exp_q[i]) begin
            wait_result(got);
            check_word($sformatf("memory result %0d", i), got, exp_q[i]);
        end
    endtask

    task automatic csr_access();
        logic [31:0] got;
        prog.delete();
        emit(csr_rwi(0, int'(CSR_TOHOST), 21));
        emit(csr_rw(5, int'(CSR_CYCLE), 0));
        emit(csr_rw(6, int'(CSR_CYCLE), 0));
        emit(r_type(7'h00, 6, 5, 3, 7));
        emit_report_halt(7);
        load_program();
        start_program();
        wait_result(got);
        check_word("csrwi tohost", got, 32'd21);
        wait_result(got);
        check_word("cycle increases", got, 32'd1);
    endtask

    task automatic random_immediates();
        logic [31:0] acc;
        logic [31:0] got;
        int          imm;
        prog.delete();
        acc = 32'd0;
        emit(addi(1, 0, 0));
        for (int i = 0; i < 20; i++) begin
            imm = int'($urandom() % 4096);
            if (i % 2 == 0) begin
                emit(addi(1, 1, imm));
                acc = acc + sext12(imm);
            end else begin
                emit(i_type(imm, 1, 4, 1, OPC_OP_IMM));
                acc = acc ^ sext12(imm);
            end
        end
        emit_report_halt(1);
        load_program();
        start_program();
        wait_result(got);
        check_word("random immediates", got, acc);
    endtask

    task automatic reset_rerun();
        logic [31:0] got;
        build_countdown(10);
        load_program();
        start_program();
        repeat (12) @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (30) begin
            @(negedge clk);
            check_bit("tohost_valid after reset", tohost_valid, 1'b0);
        end
        start_program();
        wait_result(got);
        check_word("rerun after reset", got, 32'd55);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        run          = 1'b0;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = 32'd0;
        cycle_limit  = 2000;
        errors       = 0;
        void'($urandom(32'h1f7fa55b));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        dependent_alu_chain();
        branch_and_jump();
        load_store_lanes();
        csr_access();
        random_immediates();
        reset_rerun();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/riscv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module riscv_core #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter int          IMEM_ADDR_W = 10,
    parameter int          DMEM_ADDR_W = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   imem_wr_en,
    input  logic [IMEM_ADDR_W-1:0] imem_wr_addr,
    input  logic [31:0]            imem_wr_data,
    output logic [31:0]            tohost,
    output logic                   tohost_valid
);
    import riscv_pkg::*;

    // fetch and decode
    inst_t       inst;
    logic [31:0] pc_d;
    logic [31:0] pc_plus4_d;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] rs1_d;
    logic [31:0] rs2_d;
    logic [31:0] imm_d;

    // control
    imm_sel_e    imm_sel;
    alu_op_e     alu_op;
    st_sel_e     st_sel;
    ld_sel_e     ld_sel;
    wb_sel_e     wb_sel;
    logic        rf_we;
    logic        fwd_a_d;
    logic        fwd_b_d;
    logic        fwd_a_x;
    logic        fwd_b_x;
    logic        a_sel;
    logic        b_sel;
    logic        br_un;
    logic        dmem_en;
    logic        csr_we;
    logic        csr_imm;
    logic [11:0] csr_addr;
    logic        pc_sel;
    logic        flush;

    // execute
    logic [31:0] pc_x;
    logic [31:0] pc_plus4_x;
    logic [31:0] rs1_x;
    logic [31:0] rs2_x;
    logic [31:0] imm_x;
    logic [4:0]  uimm_x;
    logic [4:0]  rd_x;
    logic [31:0] rs1_xf;
    logic [31:0] rs2_xf;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic        br_eq;
    logic        br_lt;

    // memory and write-back
    logic [31:0] alu_w;
    logic [31:0] pc_plus4_w;
    logic [4:0]  rd_w;
    logic [31:0] ld_data;
    logic [31:0] csr_rdata;
    logic [31:0] wd;

    fetch_unit #(
        .RESET_PC    (RESET_PC),
        .IMEM_ADDR_W (IMEM_ADDR_W)
    ) i_fetch_unit (
        .clk(clk), .rst(rst), .run(run), .flush(flush),
        .pc_sel(pc_sel), .alu_out(alu_out),
        .imem_wr_en(imem_wr_en), .imem_wr_addr(imem_wr_addr), .imem_wr_data(imem_wr_data),
        .inst(inst), .pc_d(pc_d), .pc_plus4_d(pc_plus4_d)
    );

    decoder i_decoder (
        .clk(clk), .rst(rst), .inst(inst), .br_eq(br_eq), .br_lt(br_lt),
        .rf_we(rf_we), .imm_sel(imm_sel),
        .fwd_a_d(fwd_a_d), .fwd_b_d(fwd_b_d), .fwd_a_x(fwd_a_x), .fwd_b_x(fwd_b_x),
        .a_sel(a_sel), .b_sel(b_sel), .br_un(br_un), .alu_op(alu_op),
        .st_sel(st_sel), .ld_sel(ld_sel), .dmem_en(dmem_en), .wb_sel(wb_sel),
        .csr_we(csr_we), .csr_imm(csr_imm), .csr_addr(csr_addr),
        .pc_sel(pc_sel), .flush(flush)
    );

    reg_file i_reg_file (
        .clk(clk), .we(rf_we),
        .ra1(inst.r_fmt.rs1), .ra2(inst.r_fmt.rs2), .wa(rd_w), .wd(wd),
        .rd1(rd1), .rd2(rd2)
    );

    imm_gen i_imm_gen (
        .inst(inst), .imm_sel(imm_sel), .imm(imm_d)
    );

    assign rs1_d = fwd_a_d ? wd : rd1;
    assign rs2_d = fwd_b_d ? wd : rd2;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_x       <= 32'd0;
            pc_plus4_x <= 32'd0;
            rs1_x      <= 32'd0;
            rs2_x      <= 32'd0;
            imm_x      <= 32'd0;
            uimm_x     <= 5'd0;
            rd_x       <= 5'd0;
            alu_w      <= 32'd0;
            pc_plus4_w <= 32'd0;
            rd_w       <= 5'd0;
        end else begin
            pc_x       <= pc_d;
            pc_plus4_x <= pc_plus4_d;
            rs1_x      <= rs1_d;
            rs2_x      <= rs2_d;
            imm_x      <= imm_d;
            uimm_x     <= inst.r_fmt.rs1;
            rd_x       <= inst.r_fmt.rd;
            alu_w      <= alu_out;
            pc_plus4_w <= pc_plus4_x;
            rd_w       <= rd_x;
        end
    end

    // second forwarding point covers the immediately preceding instruction
    assign rs1_xf = fwd_a_x ? wd : rs1_x;
    assign rs2_xf = fwd_b_x ? wd : rs2_x;
    assign op_a   = a_sel ? pc_x : rs1_xf;
    assign op_b   = b_sel ? imm_x : rs2_xf;

    alu i_alu (
        .op_a(op_a), .op_b(op_b), .alu_op(alu_op), .br_un(br_un),
        .cmp_a(rs1_xf), .cmp_b(rs2_xf),
        .alu_out(alu_out), .br_eq(br_eq), .br_lt(br_lt)
    );

    lsu #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) i_lsu (
        .clk(clk), .rst(rst), .en(dmem_en), .st_sel(st_sel),
        .addr(alu_out), .store_data(rs2_xf),
        .ld_sel(ld_sel), .ld_offset(alu_w[1:0]), .ld_data(ld_data)
    );

    csr_unit i_csr_unit (
        .clk(clk), .rst(rst), .run(run), .we(csr_we), .addr(csr_addr),
        .wdata_reg(rs1_xf), .uimm(uimm_x), .use_imm(csr_imm),
        .rdata(csr_rdata), .tohost(tohost), .tohost_valid(tohost_valid)
    );

    assign wd = (wb_sel == WB_LOAD) ? ld_data :
                (wb_sel == WB_PC4)  ? pc_plus4_w :
                (wb_sel == WB_CSR)  ? csr_rdata : alu_w;

endmodule

`default_nettype wire

// ==== hw/csr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        we,
    input  logic [11:0] addr,
    input  logic [31:0] wdata_reg,
    input  logic [4:0]  uimm,
    input  logic        use_imm,
    output logic [31:0] rdata,
    output logic [31:0] tohost,
    output logic        tohost_valid
);
    import riscv_pkg::*;

    logic [31:0] cycle;
    logic [31:0] wdata;
    logic        tohost_wr;

    assign wdata     = use_imm ? {27'd0, uimm} : wdata_reg;
    assign tohost_wr = we && (addr == CSR_TOHOST);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle        <= 32'd0;
            tohost       <= 32'd0;
            tohost_valid <= 1'b0;
        end else begin
            if (run) begin
                cycle <= cycle + 32'd1;
            end
            if (tohost_wr) begin
                tohost <= wdata;
            end
            // one-cycle report right after the write
            tohost_valid <= tohost_wr;
        end
    end

    // registered so the old value arrives with the write-back stage
    always_ff @(posedge clk) begin
        rdata <= (addr == CSR_CYCLE) ? cycle : tohost;
    end

endmodule

`default_nettype wire

// ==== hw/lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu #(
    parameter int DMEM_ADDR_W = 10
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  riscv_pkg::st_sel_e st_sel,
    input  logic [31:0]        addr,
    input  logic [31:0]        store_data,
    input  riscv_pkg::ld_sel_e ld_sel,
    input  logic [1:0]         ld_offset,
    output logic [31:0]        ld_data
);
    import riscv_pkg::*;

    logic [31:0]            dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] idx;
    logic [31:0]            lane_data;
    logic [3:0]             lane_we;
    logic [31:0]            rdata;
    logic [31:0]            rshift;

    assign idx = addr[DMEM_ADDR_W+1:2];

    // replicate the store value, enable only the addressed lanes
    always_comb begin
        lane_data = store_data;
        lane_we   = 4'b0000;
        case (st_sel)
            ST_B: begin
                lane_data = {4{store_data[7:0]}};
                lane_we   = 4'b0001 << addr[1:0];
            end
            ST_H: begin
                lane_data = {2{store_data[15:0]}};
                lane_we   = 4'b0011 << {addr[1], 1'b0};
            end
            ST_W: lane_we = 4'b1111;
            default: lane_we = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en && !rst) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_we[i]) begin
                    dmem[idx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
            rdata <= dmem[idx];
        end
    end

    // offset comes from the write-back copy of the address
    assign rshift = rdata >> {ld_offset, 3'b000};

    always_comb begin
        case (ld_sel)
            LD_B:    ld_data = {{24{rshift[7]}}, rshift[7:0]};
            LD_H:    ld_data = {{16{rshift[15]}}, rshift[15:0]};
            LD_BU:   ld_data = {24'd0, rshift[7:0]};
            LD_HU:   ld_data = {16'd0, rshift[15:0]};
            default: ld_data = rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [31:0]        op_a,
    input  logic [31:0]        op_b,
    input  riscv_pkg::alu_op_e alu_op,
    input  logic               br_un,
    input  logic [31:0]        cmp_a,
    input  logic [31:0]        cmp_b,
    output logic [31:0]        alu_out,
    output logic               br_eq,
    output logic               br_lt
);
    import riscv_pkg::*;

    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_COPY_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // branch compare works on register values, not on the operand muxes
    assign br_eq = (cmp_a == cmp_b);
    assign br_lt = br_un ? (cmp_a < cmp_b) : ($signed(cmp_a) < $signed(cmp_b));

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  riscv_pkg::inst_t    inst,
    input  riscv_pkg::imm_sel_e imm_sel,
    output logic [31:0]         imm
);
    import riscv_pkg::*;

    always_comb begin
        case (imm_sel)
            IMM_I: imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
            IMM_S: imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            // branch and jump offsets are in half-words
            IMM_B: imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                          inst.b_fmt.imm_4_1, 1'b0};
            IMM_U: imm = {inst.u_fmt.imm, 12'd0};
            IMM_J: imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                          inst.j_fmt.imm_10_1, 1'b0};
            default: imm = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads as zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  logic                clk,
    input  logic                rst,
    input  riscv_pkg::inst_t    inst,
    input  logic                br_eq,
    input  logic                br_lt,
    output logic                rf_we,
    output riscv_pkg::imm_sel_e imm_sel,
    output logic                fwd_a_d,
    output logic                fwd_b_d,
    output logic                fwd_a_x,
    output logic                fwd_b_x,
    output logic                a_sel,
    output logic                b_sel,
    output logic                br_un,
    output riscv_pkg::alu_op_e  alu_op,
    output riscv_pkg::st_sel_e  st_sel,
    output riscv_pkg::ld_sel_e  ld_sel,
    output logic                dmem_en,
    output riscv_pkg::wb_sel_e  wb_sel,
    output logic                csr_we,
    output logic                csr_imm,
    output logic [11:0]         csr_addr,
    output logic                pc_sel,
    output logic                flush
);
    import riscv_pkg::*;

    inst_t      inst_x;
    inst_t      inst_w;
    opcode_e    op_x;
    opcode_e    op_w;
    logic [2:0] f3_x;
    logic       br_cond;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_x <= NOP_INST;
            inst_w <= NOP_INST;
        end else begin
            inst_x <= inst;
            inst_w <= inst_x;
        end
    end

    assign op_x = inst_x.r_fmt.opcode;
    assign op_w = inst_w.r_fmt.opcode;
    assign f3_x = inst_x.r_fmt.funct3;

    // first stage
    always_comb begin
        case (inst.r_fmt.opcode)
            OPC_STORE:          imm_sel = IMM_S;
            OPC_BRANCH:         imm_sel = IMM_B;
            OPC_LUI, OPC_AUIPC: imm_sel = IMM_U;
            OPC_JAL:            imm_sel = IMM_J;
            default:            imm_sel = IMM_I;
        endcase
    end

    // forward the write-back result over the register file
    assign fwd_a_d = rf_we && (inst_w.r_fmt.rd == inst.r_fmt.rs1);
    assign fwd_b_d = rf_we && (inst_w.r_fmt.rd == inst.r_fmt.rs2);
    assign fwd_a_x = rf_we && (inst_w.r_fmt.rd == inst_x.r_fmt.rs1);
    assign fwd_b_x = rf_we && (inst_w.r_fmt.rd == inst_x.r_fmt.rs2);

    // execute stage
    assign a_sel = op_x inside {OPC_BRANCH, OPC_JAL, OPC_AUIPC};
    assign b_sel = (op_x != OPC_OP);
    assign br_un = f3_x[1];

    always_comb begin
        case (op_x)
            OPC_OP:     alu_op = alu_op_e'({inst_x.r_fmt.funct7[5], f3_x});
            // srai is the only immediate op that reads bit 30
            OPC_OP_IMM: alu_op = alu_op_e'({(f3_x == 3'b101) && inst_x.r_fmt.funct7[5], f3_x});
            OPC_LUI:    alu_op = ALU_COPY_B;
            default:    alu_op = ALU_ADD;
        endcase
    end

    assign st_sel   = (op_x == OPC_STORE) ? st_sel_e'(f3_x[1:0] + 2'd1) : ST_NONE;
    assign dmem_en  = (op_x == OPC_LOAD) || (op_x == OPC_STORE);
    assign csr_we   = (op_x == OPC_SYSTEM) && (f3_x[1:0] == 2'b01);
    assign csr_imm  = f3_x[2];
    assign csr_addr = inst_x.i_fmt.imm;

    // funct3[0] inverts the sense: bne, bge, bgeu
    assign br_cond = (f3_x[2] ? br_lt : br_eq) ^ f3_x[0];
    assign pc_sel  = (op_x == OPC_JAL) || (op_x == OPC_JALR) ||
                     ((op_x == OPC_BRANCH) && br_cond);
    assign flush   = pc_sel;

    // write-back stage
    assign rf_we  = (op_w inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OP,
                                  OPC_OP_IMM, OPC_LOAD, OPC_SYSTEM}) &&
                    (inst_w.r_fmt.rd != 5'd0);
    assign ld_sel = ld_sel_e'(inst_w.r_fmt.funct3);

    always_comb begin
        case (op_w)
            OPC_LOAD:          wb_sel = WB_LOAD;
            OPC_JAL, OPC_JALR: wb_sel = WB_PC4;
            OPC_SYSTEM:        wb_sel = WB_CSR;
            default:           wb_sel = WB_ALU;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter int          IMEM_ADDR_W = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   flush,
    input  logic                   pc_sel,
    input  logic [31:0]            alu_out,
    input  logic                   imem_wr_en,
    input  logic [IMEM_ADDR_W-1:0] imem_wr_addr,
    input  logic [31:0]            imem_wr_data,
    output riscv_pkg::inst_t       inst,
    output logic [31:0]            pc_d,
    output logic [31:0]            pc_plus4_d
);
    import riscv_pkg::*;

    logic [31:0] imem [2**IMEM_ADDR_W];
    logic [31:0] imem_q;
    logic [31:0] pc_next;
    logic        run_q;

    assign pc_plus4_d = pc_d + 32'd4;

    // park on the reset vector until released
    always_comb begin
        if (!run_q) begin
            pc_next = RESET_PC;
        end else if (pc_sel) begin
            pc_next = {alu_out[31:1], 1'b0};
        end else begin
            pc_next = pc_plus4_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
            pc_d  <= RESET_PC;
        end else begin
            run_q <= run;
            pc_d  <= pc_next;
        end
    end

    // memory is addressed with the next pc, so its output lines up with pc_d
    always_ff @(posedge clk) begin
        if (imem_wr_en && !run) begin
            imem[imem_wr_addr] <= imem_wr_data;
        end
        imem_q <= imem[pc_next[IMEM_ADDR_W+1:2]];
    end

    // kill the slot behind a taken branch
    assign inst = (!run_q || flush) ? NOP_INST : imem_q;

endmodule

`default_nettype wire

// ==== hw/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // low three bits follow funct3, bit 3 follows funct7[5]
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_COPY_B = 4'b1111
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    // load codes match funct3
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } ld_sel_e;

    typedef enum logic [1:0] {ST_NONE, ST_B, ST_H, ST_W} st_sel_e;

    typedef enum logic [1:0] {WB_LOAD, WB_ALU, WB_PC4, WB_CSR} wb_sel_e;

    typedef enum logic [11:0] {
        CSR_TOHOST = 12'h51E,
        CSR_CYCLE  = 12'hC00
    } csr_addr_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire
